// ==== source/udp_rx_pkg.sv ====
`default_nettype none

package udp_rx_pkg;

    localparam int IP_HDR_BYTES  = 20;
    localparam int UDP_HDR_BYTES = 8;
    localparam int HDR_BYTES     = 14 + IP_HDR_BYTES + UDP_HDR_BYTES; // ethernet header is 14 bytes

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

    localparam int BUF_ADDR_W = 11; // 2048 byte payload buffer
    localparam int CNT_W      = 16;

    // fields in wire order, first received byte sits in the top byte
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
        logic [7:0]  ip_ver_ihl;
        logic [7:0]  ip_tos;
        logic [15:0] ip_total_len;
        logic [15:0] ip_id;
        logic [15:0] ip_frag;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_proto;
        logic [15:0] ip_csum;
        logic [31:0] ip_src;
        logic [31:0] ip_dst;
        logic [15:0] udp_src_port;
        logic [15:0] udp_dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_csum;
    } eth_udp_hdr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } pay_beat_t;

    typedef struct packed {
        logic frame_end; // pulses once per frame when rx_dv drops
        logic good;
    } frame_status_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } out_beat_t;

    typedef enum logic [2:0] {
        PS_IDLE,
        PS_PREAMBLE,
        PS_HEADER,
        PS_PAYLOAD,
        PS_SKIP
    } parser_state_t;

endpackage

`default_nettype wire

// ==== source/rx_frame_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_frame_parser (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic [7:0]               rx_d_i,
    input  wire logic                     rx_dv_i,
    output udp_rx_pkg::eth_udp_hdr_t      hdr_o,
    output logic                          hdr_done_o,
    output udp_rx_pkg::pay_beat_t         pay_o,
    output udp_rx_pkg::frame_status_t     status_o
);

    logic [7:0]                rxd_q;
    logic                      rxdv_q;
    logic                      rxdv_d;
    udp_rx_pkg::parser_state_t state;
    udp_rx_pkg::eth_udp_hdr_t  hdr_q;
    logic [15:0]               byte_cnt;
    logic [15:0]               pay_len;
    logic                      hdr_last;
    logic                      short_udp;
    logic                      pay_done;
    logic [7:0]                pay_data_q;
    logic                      pay_valid_q;

    assign pay_len   = hdr_q.udp_len - 16'(udp_rx_pkg::UDP_HDR_BYTES);
    assign short_udp = (hdr_q.udp_len <= 16'(udp_rx_pkg::UDP_HDR_BYTES)); // no payload at all
    assign hdr_last  = (byte_cnt == 16'(udp_rx_pkg::HDR_BYTES - 1));

    assign hdr_o = hdr_q;
    assign pay_o = '{data: pay_data_q, valid: pay_valid_q};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxdv_q <= 1'b0;
            rxdv_d <= 1'b0;
        end else begin
            rxdv_q <= rx_dv_i;
            rxdv_d <= rxdv_q; // used for the rising edge in idle
        end
    end

    always_ff @(posedge clk_i) begin
        rxd_q <= rx_d_i;
        if (state == udp_rx_pkg::PS_HEADER && rxdv_q) begin
            hdr_q <= {hdr_q[udp_rx_pkg::HDR_BYTES*8-9:0], rxd_q};
        end
        if (state == udp_rx_pkg::PS_PAYLOAD) begin
            pay_data_q <= rxd_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state       <= udp_rx_pkg::PS_IDLE;
            byte_cnt    <= '0;
            pay_done    <= 1'b0;
            hdr_done_o  <= 1'b0;
            pay_valid_q <= 1'b0;
            status_o    <= '0;
        end else begin
            hdr_done_o  <= 1'b0;
            pay_valid_q <= 1'b0;
            status_o    <= '0;
            if (state != udp_rx_pkg::PS_IDLE && !rxdv_q) begin
                state              <= udp_rx_pkg::PS_IDLE;
                status_o.frame_end <= 1'b1;
                status_o.good      <= (state == udp_rx_pkg::PS_SKIP) && pay_done;
            end else begin
                case (state)
                    udp_rx_pkg::PS_IDLE: begin
                        byte_cnt <= '0;
                        pay_done <= 1'b0;
                        if (rxdv_q && !rxdv_d) begin
                            state <= udp_rx_pkg::PS_PREAMBLE;
                        end
                    end
                    udp_rx_pkg::PS_PREAMBLE: begin
                        if (rxd_q == udp_rx_pkg::SFD_BYTE) begin
                            state <= udp_rx_pkg::PS_HEADER;
                        end else if (rxd_q != udp_rx_pkg::PREAMBLE_BYTE) begin
                            state <= udp_rx_pkg::PS_SKIP; // malformed preamble, frame is bad
                        end
                    end
                    udp_rx_pkg::PS_HEADER: begin
                        byte_cnt <= byte_cnt + 16'd1;
                        if (hdr_last) begin
                            state      <= udp_rx_pkg::PS_PAYLOAD;
                            byte_cnt   <= '0;
                            hdr_done_o <= 1'b1;
                        end
                    end
                    udp_rx_pkg::PS_PAYLOAD: begin
                        if (short_udp) begin
                            state <= udp_rx_pkg::PS_SKIP;
                        end else begin
                            pay_valid_q <= 1'b1;
                            byte_cnt    <= byte_cnt + 16'd1;
                            if (byte_cnt == pay_len - 16'd1) begin
                                state    <= udp_rx_pkg::PS_SKIP;
                                pay_done <= 1'b1;
                            end
                        end
                    end
                    udp_rx_pkg::PS_SKIP: begin
                        state <= udp_rx_pkg::PS_SKIP; // padding and fcs until rx_dv drops
                    end
                    default: begin
                        state <= udp_rx_pkg::PS_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/header_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module header_filter (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire udp_rx_pkg::eth_udp_hdr_t hdr_i,
    input  wire logic                     hdr_done_i,
    input  wire logic                     frame_end_i,
    input  wire logic [47:0]              local_mac_i,
    input  wire logic [31:0]              local_ip_i,
    input  wire logic [15:0]              local_port_i,
    output logic                          accept_o,
    output logic                          verdict_valid_o
);

    logic is_udp;
    logic addr_match;

    assign is_udp = (hdr_i.ethertype == udp_rx_pkg::ETHERTYPE_IPV4) &&
                    (hdr_i.ip_proto == udp_rx_pkg::IP_PROTO_UDP);

    assign addr_match = (hdr_i.dst_mac == local_mac_i) &&
                        (hdr_i.ip_dst == local_ip_i) &&
                        (hdr_i.udp_dst_port == local_port_i);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            accept_o        <= 1'b0;
            verdict_valid_o <= 1'b0;
        end else begin
            if (hdr_done_i) begin
                accept_o        <= is_udp && addr_match;
                verdict_valid_o <= 1'b1;
            end else if (frame_end_i) begin
                verdict_valid_o <= 1'b0; // the commit logic samples it on this same edge
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/payload_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module payload_buffer (
    input  wire logic                  clk_i,
    input  wire logic                  rst_i,
    input  wire udp_rx_pkg::pay_beat_t pay_i,
    input  wire logic                  commit_i,
    input  wire logic                  discard_i,
    output logic                       overflow_o,
    output udp_rx_pkg::out_beat_t      m_beat_o,
    output logic                       m_valid_o,
    input  wire logic                  m_ready_i
);

    logic [7:0] data_mem [2**udp_rx_pkg::BUF_ADDR_W];
    logic       last_mem [2**udp_rx_pkg::BUF_ADDR_W];

    // one extra pointer bit tells a full buffer from an empty one
    logic [udp_rx_pkg::BUF_ADDR_W:0]   wr_ptr;
    logic [udp_rx_pkg::BUF_ADDR_W:0]   cm_ptr;
    logic [udp_rx_pkg::BUF_ADDR_W:0]   rd_ptr;
    logic [udp_rx_pkg::BUF_ADDR_W:0]   fill;
    logic [udp_rx_pkg::BUF_ADDR_W-1:0] last_addr;
    logic                              full;
    logic                              wr_en;
    logic                              avail;
    logic                              rd_en;
    udp_rx_pkg::out_beat_t             beat_q;

    assign fill      = wr_ptr - rd_ptr;
    assign full      = fill[udp_rx_pkg::BUF_ADDR_W]; // set only when fill equals the depth
    assign wr_en     = pay_i.valid && !full;
    assign avail     = (rd_ptr != cm_ptr); // only committed bytes are readable
    assign rd_en     = avail && (!m_valid_o || m_ready_i);
    assign last_addr = wr_ptr[udp_rx_pkg::BUF_ADDR_W-1:0] - 1'b1;
    assign m_beat_o  = beat_q;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            data_mem[wr_ptr[udp_rx_pkg::BUF_ADDR_W-1:0]] <= pay_i.data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (commit_i) begin
            last_mem[last_addr] <= 1'b1; // marks the final byte of the packet
        end else if (wr_en) begin
            last_mem[wr_ptr[udp_rx_pkg::BUF_ADDR_W-1:0]] <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            beat_q.data <= data_mem[rd_ptr[udp_rx_pkg::BUF_ADDR_W-1:0]];
            beat_q.last <= last_mem[rd_ptr[udp_rx_pkg::BUF_ADDR_W-1:0]];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr     <= '0;
            cm_ptr     <= '0;
            rd_ptr     <= '0;
            overflow_o <= 1'b0;
            m_valid_o  <= 1'b0;
        end else begin
            if (discard_i) begin
                wr_ptr <= cm_ptr; // rejected bytes vanish
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (commit_i) begin
                cm_ptr <= wr_ptr;
            end
            if (commit_i || discard_i) begin
                overflow_o <= 1'b0;
            end else if (pay_i.valid && full) begin
                overflow_o <= 1'b1;
            end
            if (rd_en) begin
                rd_ptr    <= rd_ptr + 1'b1;
                m_valid_o <= 1'b1;
            end else if (m_ready_i) begin
                m_valid_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/rx_commit_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_commit_ctrl (
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire udp_rx_pkg::frame_status_t status_i,
    input  wire logic                      accept_i,
    input  wire logic                      verdict_valid_i,
    input  wire logic                      overflow_i,
    output logic                           commit_o,
    output logic                           discard_o,
    output logic [udp_rx_pkg::CNT_W-1:0]   accept_count_o,
    output logic [udp_rx_pkg::CNT_W-1:0]   drop_count_o
);

    logic keep;

    assign keep = status_i.good && verdict_valid_i && accept_i && !overflow_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            commit_o       <= 1'b0;
            discard_o      <= 1'b0;
            accept_count_o <= '0;
            drop_count_o   <= '0;
        end else begin
            commit_o  <= status_i.frame_end && keep;
            discard_o <= status_i.frame_end && !keep;
            if (status_i.frame_end) begin
                if (keep) begin
                    if (accept_count_o != '1) begin
                        accept_count_o <= accept_count_o + 1'b1; // saturating
                    end
                end else if (drop_count_o != '1) begin
                    drop_count_o <= drop_count_o + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/udp_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_rx_top (
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,
    input  wire logic [7:0]              rx_d_i,
    input  wire logic                    rx_dv_i,
    input  wire logic [47:0]             local_mac_i,
    input  wire logic [31:0]             local_ip_i,
    input  wire logic [15:0]             local_port_i,
    output udp_rx_pkg::out_beat_t        m_beat_o,
    output logic                         m_valid_o,
    input  wire logic                    m_ready_i,
    output logic [udp_rx_pkg::CNT_W-1:0] accept_count_o,
    output logic [udp_rx_pkg::CNT_W-1:0] drop_count_o
);

    udp_rx_pkg::eth_udp_hdr_t  hdr;
    udp_rx_pkg::pay_beat_t     pay;
    udp_rx_pkg::frame_status_t status;
    logic                      hdr_done;
    logic                      accept;
    logic                      verdict_valid;
    logic                      overflow;
    logic                      commit;
    logic                      discard;

    rx_frame_parser u_parser (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rx_d_i     (rx_d_i),
        .rx_dv_i    (rx_dv_i),
        .hdr_o      (hdr),
        .hdr_done_o (hdr_done),
        .pay_o      (pay),
        .status_o   (status)
    );

    header_filter u_filter (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .hdr_i           (hdr),
        .hdr_done_i      (hdr_done),
        .frame_end_i     (status.frame_end),
        .local_mac_i     (local_mac_i),
        .local_ip_i      (local_ip_i),
        .local_port_i    (local_port_i),
        .accept_o        (accept),
        .verdict_valid_o (verdict_valid)
    );

    payload_buffer u_buffer (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .pay_i      (pay),
        .commit_i   (commit),
        .discard_i  (discard),
        .overflow_o (overflow),
        .m_beat_o   (m_beat_o),
        .m_valid_o  (m_valid_o),
        .m_ready_i  (m_ready_i)
    );

    rx_commit_ctrl u_commit (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .status_i        (status),
        .accept_i        (accept),
        .verdict_valid_i (verdict_valid),
        .overflow_i      (overflow),
        .commit_o        (commit),
        .discard_o       (discard),
        .accept_count_o  (accept_count_o),
        .drop_count_o    (drop_count_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_frame_gen.svh ====
`ifndef TB_FRAME_GEN_SVH
`define TB_FRAME_GEN_SVH

logic [7:0]  frame_q[$];             // bytes of the frame being built, preamble first
logic [31:0] rnd_state = 32'd80856;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [7:0] rand_byte();
    rnd_state = lcg_next(rnd_state);
    return rnd_state[23:16]; // low bits of an lcg repeat too quickly
endfunction

// expected outcome of one frame, from the filter, frame and buffer space rules
function automatic bit packet_kept(input logic [15:0] ethertype, input logic [7:0] proto,
                                   input logic [47:0] mac, input logic [31:0] ip,
                                   input logic [15:0] port, input int len, input bit cut);
    bit match;
    bit good;
    bit fits;
    match = (ethertype == 16'h0800) && (proto == 8'd17) && (mac == LOCAL_MAC) &&
            (ip == LOCAL_IP) && (port == LOCAL_PORT);
    good  = !cut && (len > 0);
    fits  = (exp_q.size() + len) <= BUF_BYTES; // committed bytes still waiting to be read
    return match && good && fits;
endfunction

task automatic build_frame(input logic [15:0] ethertype, input logic [7:0] proto,
                           input logic [47:0] mac, input logic [31:0] ip,
                           input logic [15:0] port, input int len, input int cut_at);
    udp_rx_pkg::eth_udp_hdr_t hdr;
    logic [335:0]             hdr_bits;
    logic [7:0]               pay[$];
    int                       body;
    hdr              = '0;
    hdr.dst_mac      = mac;
    hdr.src_mac      = 48'h02_00_00_00_00_99;
    hdr.ethertype    = ethertype;
    hdr.ip_ver_ihl   = 8'h45;
    hdr.ip_total_len = 16'(28 + len);
    hdr.ip_id        = {rand_byte(), rand_byte()};
    hdr.ip_frag      = 16'h4000;
    hdr.ip_ttl       = 8'd64;
    hdr.ip_proto     = proto;
    hdr.ip_src       = 32'hC0A8_0001;
    hdr.ip_dst       = ip;
    hdr.udp_src_port = 16'd5000;
    hdr.udp_dst_port = port;
    hdr.udp_len      = 16'(8 + len);
    hdr_bits         = hdr;
    frame_q.delete();
    for (int i = 0; i < 7; i++) begin
        frame_q.push_back(8'h55);
    end
    frame_q.push_back(8'hD5);
    for (int i = 0; i < 42; i++) begin
        frame_q.push_back(hdr_bits[335 - 8*i -: 8]); // network order, top byte first
    end
    for (int i = 0; i < len; i++) begin
        pay.push_back(rand_byte());
        frame_q.push_back(pay[i]);
    end
    for (body = 42 + len; body < 60; body++) begin
        frame_q.push_back(8'h00); // pad up to the ethernet minimum
    end
    for (int i = 0; i < 4; i++) begin
        frame_q.push_back(rand_byte());
    end
    if (cut_at >= 0) begin
        while (frame_q.size() > 8 + cut_at) begin
            void'(frame_q.pop_back());
        end
    end
    if (packet_kept(ethertype, proto, mac, ip, port, len, cut_at >= 0)) begin
        foreach (pay[i]) begin
            exp_q.push_back({pay[i], i == len - 1});
        end
        acc_exp++;
    end else begin
        drop_exp++;
    end
endtask

`endif

// ==== tb/tb_udp_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_udp_rx_top;

    localparam logic [47:0] LOCAL_MAC  = 48'h02_11_22_33_44_55;
    localparam logic [31:0] LOCAL_IP   = 32'hC0A8_0164;
    localparam logic [15:0] LOCAL_PORT = 16'd1234;
    localparam int          BUF_BYTES  = 2048;
    localparam int          GAP_CYCLES = 12;
    localparam int          MARGIN     = 1000;
    localparam int          READY_HIGH = 0;
    localparam int          READY_RAND = 1;
    localparam int          READY_LOW  = 2;

    logic                  clk;
    logic                  rst;
    logic [7:0]            rx_d;
    logic                  rx_dv;
    udp_rx_pkg::out_beat_t m_beat;
    logic                  m_valid;
    logic                  m_ready;
    logic [15:0]           accept_count;
    logic [15:0]           drop_count;

    logic [8:0]  exp_q[$]; // data and last of every byte the DUT should deliver
    logic [8:0]  want_beat;
    int          acc_exp = 0;
    int          drop_exp = 0;
    int          ready_mode = READY_HIGH;
    int unsigned bytes_sent = 0;
    int unsigned cycles = 0;
    logic [31:0] ready_state = 32'd80856;

    `include "tb_frame_gen.svh"

    udp_rx_top uut (
        .clk_i          (clk),
        .rst_i          (rst),
        .rx_d_i         (rx_d),
        .rx_dv_i        (rx_dv),
        .local_mac_i    (LOCAL_MAC),
        .local_ip_i     (LOCAL_IP),
        .local_port_i   (LOCAL_PORT),
        .m_beat_o       (m_beat),
        .m_valid_o      (m_valid),
        .m_ready_i      (m_ready),
        .accept_count_o (accept_count),
        .drop_count_o   (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic send_packet(input logic [15:0] ethertype, input logic [7:0] proto,
                               input logic [47:0] mac, input logic [31:0] ip,
                               input logic [15:0] port, input int len, input int cut_at);
        build_frame(ethertype, proto, mac, ip, port, len, cut_at);
        bytes_sent += frame_q.size() + GAP_CYCLES;
        foreach (frame_q[i]) begin
            @(negedge clk);
            rx_dv = 1'b1;
            rx_d  = frame_q[i];
        end
        @(negedge clk);
        rx_dv = 1'b0;
        rx_d  = 8'h00;
        repeat (GAP_CYCLES) @(negedge clk); // end pulse and commit land inside the gap
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || m_valid) begin
            @(negedge clk);
        end
        check_value("accept_count_o", acc_exp, accept_count);
        check_value("drop_count_o", drop_exp, drop_count);
    endtask

    always @(negedge clk) begin
        ready_state = lcg_next(ready_state);
        case (ready_mode)
            READY_RAND: m_ready = ready_state[20];
            READY_LOW:  m_ready = 1'b0;
            default:    m_ready = 1'b1;
        endcase
    end

    // every output transfer must match the head of the expected queue
    always @(posedge clk) begin
        if (!rst && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                fail_run("output delivered a byte while no payload was expected");
            end else begin
                want_beat = exp_q.pop_front();
                check_value("m_beat_o.data", want_beat[8:1], m_beat.data);
                check_value("m_beat_o.last", want_beat[0], m_beat.last);
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > bytes_sent * 4 + MARGIN) begin
                fail_run("watchdog expired, the output stalled");
            end
        end
    end

    initial begin
        rst     = 1'b1;
        rx_d    = 8'h00;
        rx_dv   = 1'b0;
        m_ready = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        send_packet(16'h0800, 8'd17, LOCAL_MAC, LOCAL_IP, LOCAL_PORT, 32, -1);
        wait_drain();
        send_packet(16'h0800, 8'd17, LOCAL_MAC ^ 48'h1, LOCAL_IP, LOCAL_PORT, 20, -1);
        send_packet(16'h0800, 8'd17, LOCAL_MAC, LOCAL_IP + 32'd1, LOCAL_PORT, 20, -1);
        send_packet(16'h0800, 8'd17, LOCAL_MAC, LOCAL_IP, LOCAL_PORT + 16'd1, 20, -1);
        send_packet(16'h86DD, 8'd17, LOCAL_MAC, LOCAL_IP, LOCAL_PORT, 20, -1);
        send_packet(16'h0800, 8'd6, LOCAL_MAC, LOCAL_IP, LOCAL_PORT, 20, -1);
        wait_drain();
        for (int len = 1; len <= 17; len++) begin
            send_packet(16'h0800, 8'd17, LOCAL_MAC, LOCAL_IP, LOCAL_PORT, len, -1);
        end
        send_packet(16'h0800, 8'd17, LOCAL_MAC, LOCAL_IP, LOCAL_PORT, 0, -1);
        wait_drain();
        send_packet(16'h0800, 8'd17, LOCAL_MAC, LOCAL_IP, LOCAL_PORT, 30, 20); // cut in header
        send_packet(16'h0800, 8'd17, LOCAL_MAC, LOCAL_IP, LOCAL_PORT, 40, 52); // cut in payload
        send_packet(16'h0800, 8'd17, LOCAL_MAC, LOCAL_IP, LOCAL_PORT, 25, -1);
        wait_drain();
        ready_mode = READY_RAND;
        for (int n = 0; n < 20; n++) begin
            send_packet(16'h0800, 8'd17, LOCAL_MAC, LOCAL_IP, LOCAL_PORT,
                        1 + int'(rand_byte() % 8'd64), -1);
        end
        wait_drain();
        ready_mode = READY_LOW;
        for (int n = 0; n < 7; n++) begin
            send_packet(16'h0800, 8'd17, LOCAL_MAC, LOCAL_IP, LOCAL_PORT, 300, -1);
        end
        check_value("drop_count_o", drop_exp, drop_count); // the last one found no room
        ready_mode = READY_HIGH;
        wait_drain();
        repeat (20) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+tb
source/udp_rx_pkg.sv
source/rx_frame_parser.sv
source/header_filter.sv
source/payload_buffer.sv
source/rx_commit_ctrl.sv
source/udp_rx_top.sv
tb/tb_udp_rx_top.sv

// ==== Bender.yml ====
package:
  name: udp_rx

sources:
  - source/udp_rx_pkg.sv
  - source/rx_frame_parser.sv
  - source/header_filter.sv
  - source/payload_buffer.sv
  - source/rx_commit_ctrl.sv
  - source/udp_rx_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_udp_rx_top.sv
